// File: sim/lsu_testdata.txt
# opcode funct3 rs1_val rs2_val imm load_data misaligned, all in hex.
# load_data and misaligned are the values expected while the access is presented.
03 2 00000010 00000000 00000000 00000000 0
03 2 00000400 00000000 fffffffc 00000000 0
03 2 00000104 00000000 00000000 00000000 0
23 2 00000100 deadbeef 00000000 00000000 0
03 2 000000f0 00000000 00000010 deadbeef 0
23 0 00000101 12345655 00000000 00000000 0
23 0 00000100 ffffffa7 00000003 00000000 0
03 2 00000100 00000000 00000000 a7ad55ef 0
23 1 00000102 ffff1234 00000000 00000000 0
03 2 00000100 00000000 00000000 123455ef 0
23 1 00000104 00008081 00000000 00000000 0
23 0 00000106 000000f0 00000000 00000000 0
23 0 00000107 1111119c 00000000 00000000 0
03 2 00000104 00000000 00000000 9cf08081 0
03 0 00000104 00000000 00000000 ffffff81 0
03 4 00000104 00000000 00000000 00000081 0
03 1 00000104 00000000 00000000 ffff8081 0
03 5 00000104 00000000 00000000 00008081 0
03 0 00000107 00000000 00000000 ffffff9c 0
03 0 00000105 00000000 00000000 ffffff80 0
03 1 00000106 00000000 00000000 ffff9cf0 0
03 5 00000106 00000000 00000000 00009cf0 0
23 2 00000102 ffffffff 00000000 00000000 1
23 1 00000101 ffffffff 00000000 00000000 1
03 2 00000102 00000000 00000000 00000000 1
03 1 00000103 00000000 00000000 00000000 1
03 5 00000105 00000000 00000000 00000000 1
03 2 00000100 00000000 00000000 123455ef 0
03 2 00000104 00000000 00000000 9cf08081 0
03 3 00000100 00000000 00000000 00000000 0
03 6 00000100 00000000 00000000 00000000 0
33 2 00000100 00000000 00000000 00000000 0
13 1 00000101 00000000 00000000 00000000 0

// File: lsu_top.f
+incdir+hw
hw/rv_isa_pkg.sv
hw/mem_pkg.sv
hw/key_mux.sv
hw/mem_decode.sv
hw/lsu.sv
hw/data_mem.sv
hw/lsu_top.sv
sim/lsu_top_props.sv
sim/lsu_top_tb.sv

// File: Bender.yml
package:
  name: lsu_top

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_isa_pkg.sv
      - hw/mem_pkg.sv
      - hw/key_mux.sv
      - hw/mem_decode.sv
      - hw/lsu.sv
      - hw/data_mem.sv
      - hw/lsu_top.sv
  - target: simulation
    files:
      - sim/lsu_top_props.sv
      - sim/lsu_top_tb.sv

// File: sim/lsu_top_tb.sv
module lsu_top_tb;

    localparam int RESET_CYCLES = 16;
    localparam int MARGIN       = 20;

    logic                clk = 1'b0;
    logic                reset;
    rv_isa_pkg::opcode_t opcode;
    rv_isa_pkg::funct3_t funct3;
    rv_isa_pkg::word_t   rs1_val;
    rv_isa_pkg::word_t   rs2_val;
    rv_isa_pkg::word_t   imm;
    rv_isa_pkg::word_t   load_data;
    logic                misaligned;

    rv_isa_pkg::opcode_t vec_opcode[$];
    rv_isa_pkg::funct3_t vec_funct3[$];
    rv_isa_pkg::word_t   vec_rs1[$];
    rv_isa_pkg::word_t   vec_rs2[$];
    rv_isa_pkg::word_t   vec_imm[$];
    rv_isa_pkg::word_t   vec_load[$];
    logic                vec_mis[$];

    int errors       = 0;
    int checks       = 0;
    int cycles       = 0;
    int cycle_limit  = 0;
    int assert_fails = 0;

    lsu_top lsu_top_inst (
        .clk       (clk),
        .reset     (reset),
        .opcode    (opcode),
        .funct3    (funct3),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .imm       (imm),
        .load_data (load_data),
        .misaligned(misaligned)
    );

    always #50 clk = ~clk;

    // run limit from the vector count.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [7];
        fd = $fopen("sim/lsu_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file sim/lsu_testdata.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
            if (n != 7) begin
                $display("malformed test data line: %s", line);
                errors++;
            end else begin
                vec_opcode.push_back(f[0][6:0]);
                vec_funct3.push_back(f[1][2:0]);
                vec_rs1.push_back(f[2]);
                vec_rs2.push_back(f[3]);
                vec_imm.push_back(f[4]);
                vec_load.push_back(f[5]);
                vec_mis.push_back(f[6][0]);
            end
        end
        $fclose(fd);
        if (vec_opcode.size() == 0) begin
            $display("no test vectors were found in the test data file");
            errors++;
        end
    endtask

    task automatic check_outputs(input int idx);
        if (load_data !== vec_load[idx]) begin
            $display("ERROR vector %0d: load_data expected %h, got %h",
                     idx, vec_load[idx], load_data);
            errors++;
        end
        if (misaligned !== vec_mis[idx]) begin
            $display("ERROR vector %0d: misaligned expected %h, got %h",
                     idx, vec_mis[idx], misaligned);
            errors++;
        end
        checks += 2;
    endtask

    initial begin
        reset   = 1'b1;
        opcode  = '0;
        funct3  = '0;
        rs1_val = '0;
        rs2_val = '0;
        imm     = '0;
        load_vectors();
        cycle_limit = vec_opcode.size() + RESET_CYCLES + MARGIN;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < vec_opcode.size(); i++) begin
            @(posedge clk);
            opcode  <= vec_opcode[i];
            funct3  <= vec_funct3[i];
            rs1_val <= vec_rs1[i];
            rs2_val <= vec_rs2[i];
            imm     <= vec_imm[i];
            // outputs settle well before the falling edge.
            @(negedge clk);
            check_outputs(i);
        end
        // assertions on the last access fire at the next rising edge.
        @(negedge clk);
        assert_fails = lsu_top_inst.data_mem_inst.lsu_top_props_inst.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: sim/lsu_top_props.sv
module lsu_top_props (
    input logic              clk,
    input logic              reset,
    input logic              r_en,
    input logic              w_en,
    input mem_pkg::mask_t    mask,
    input rv_isa_pkg::word_t rdata
);

    int   fail_count = 0;
    logic written;

    // set by the first write after reset.
    always_ff @(posedge clk) begin
        if (reset) begin
            written <= 1'b0;
        end else if (w_en) begin
            written <= 1'b1;
        end
    end

    // one access per cycle.
    rw_exclusive: assert property (@(posedge clk) disable iff (reset) !(r_en && w_en))
        else begin
            fail_count++;
            $error("read and write enable are high together");
        end

    // cleared memory reads back zero until the first write.
    read_cleared: assert property (@(posedge clk) disable iff (reset)
        r_en && !written |-> rdata == '0)
        else begin
            fail_count++;
            $error("read data is not zero before the first write after reset");
        end

    write_has_mask: assert property (@(posedge clk) disable iff (reset) w_en |-> mask != '0)
        else begin
            fail_count++;
            $error("write enable with an empty byte mask");
        end

endmodule

bind data_mem lsu_top_props lsu_top_props_inst (
    .clk  (clk),
    .reset(reset),
    .r_en (r_en),
    .w_en (w_en),
    .mask (mask),
    .rdata(rdata)
);

// File: hw/lsu_top.sv
module lsu_top (
    input  logic                clk,
    input  logic                reset,
    input  rv_isa_pkg::opcode_t opcode,
    input  rv_isa_pkg::funct3_t funct3,
    input  rv_isa_pkg::word_t   rs1_val,
    input  rv_isa_pkg::word_t   rs2_val,
    input  rv_isa_pkg::word_t   imm,
    output rv_isa_pkg::word_t   load_data,
    output logic                misaligned
);

    rv_isa_pkg::word_t addr;
    mem_pkg::mask_t    mem_mask;
    logic              mem_r_en;
    logic              mem_w_en;

    rv_isa_pkg::word_t mem_addr;
    mem_pkg::mask_t    mem_mask_out;
    logic              mem_r_en_out;
    logic              mem_w_en_out;
    rv_isa_pkg::word_t mem_wdata;
    rv_isa_pkg::word_t mem_rdata;

    mem_decode mem_decode_inst (
        .opcode    (opcode),
        .funct3    (funct3),
        .rs1_val   (rs1_val),
        .imm       (imm),
        .addr      (addr),
        .mem_mask  (mem_mask),
        .mem_r_en  (mem_r_en),
        .mem_w_en  (mem_w_en),
        .misaligned(misaligned)
    );

    lsu lsu_inst (
        .src2      (rs2_val),
        .alu_result(addr),
        .mem_r     (load_data),
        .funct3    (funct3),
        .mem_mask  (mem_mask),
        .mem_r_en  (mem_r_en),
        .mem_w_en  (mem_w_en),
        .mem_2_r   (mem_rdata),
        .mem_2_w   (mem_wdata),
        .mem_2_addr(mem_addr),
        .mem_2_mask(mem_mask_out),
        .mem_2_r_en(mem_r_en_out),
        .mem_2_w_en(mem_w_en_out)
    );

    data_mem data_mem_inst (
        .clk  (clk),
        .reset(reset),
        .addr (mem_addr),
        .mask (mem_mask_out),
        .r_en (mem_r_en_out),
        .w_en (mem_w_en_out),
        .wdata(mem_wdata),
        .rdata(mem_rdata)
    );

endmodule

// File: hw/data_mem.sv
`include "lsu_cfg.svh"

module data_mem (
    input  logic              clk,
    input  logic              reset,
    input  rv_isa_pkg::word_t addr,
    input  mem_pkg::mask_t    mask,
    input  logic              r_en,
    input  logic              w_en,
    input  rv_isa_pkg::word_t wdata,
    output rv_isa_pkg::word_t rdata
);

    localparam int DEPTH  = 2 ** `MEM_AW;
    localparam int OFF_W  = $bits(mem_pkg::offset_t);
    localparam int LANES  = $bits(mem_pkg::mask_t);

    rv_isa_pkg::word_t mem [DEPTH];
    mem_pkg::index_t   index;
    mem_pkg::offset_t  offset;
    mem_pkg::mask_t    lane_en;
    rv_isa_pkg::word_t lane_data;

    // upper address bits wrap.
    assign offset = addr[OFF_W-1:0];
    assign index  = addr[OFF_W +: `MEM_AW];

    // move request lanes up to the byte offset.
    assign lane_en   = mask << offset;
    assign lane_data = wdata << {offset, 3'b000};

    // bring the addressed byte down to lane 0.
    assign rdata = r_en ? (mem[index] >> {offset, 3'b000}) : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (w_en) begin
            for (int b = 0; b < LANES; b++) begin
                if (lane_en[b]) begin
                    mem[index][8*b +: 8] <= lane_data[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: hw/lsu.sv
`include "lsu_cfg.svh"

module lsu (
    input  rv_isa_pkg::word_t   src2,
    input  rv_isa_pkg::word_t   alu_result,
    output rv_isa_pkg::word_t   mem_r,
    input  rv_isa_pkg::funct3_t funct3,
    input  mem_pkg::mask_t      mem_mask,
    input  logic                mem_r_en,
    input  logic                mem_w_en,
    input  rv_isa_pkg::word_t   mem_2_r,
    output rv_isa_pkg::word_t   mem_2_w,
    output rv_isa_pkg::word_t   mem_2_addr,
    output mem_pkg::mask_t      mem_2_mask,
    output logic                mem_2_r_en,
    output logic                mem_2_w_en
);

    // load data extension.
    key_mux #(
        .NR_KEY(`LD_NR_KEY),
        .key_t (rv_isa_pkg::funct3_t),
        .data_t(rv_isa_pkg::word_t)
    ) load_mux (
        .out        (mem_r),
        .key        (funct3),
        .default_out(rv_isa_pkg::word_t'(0)),
        .lut        ({
            rv_isa_pkg::F3_B,  {{(`XLEN-8){mem_2_r[7]}}, mem_2_r[7:0]},
            rv_isa_pkg::F3_H,  {{(`XLEN-16){mem_2_r[15]}}, mem_2_r[15:0]},
            rv_isa_pkg::F3_W,  mem_2_r,
            rv_isa_pkg::F3_BU, {{(`XLEN-8){1'b0}}, mem_2_r[7:0]},
            rv_isa_pkg::F3_HU, {{(`XLEN-16){1'b0}}, mem_2_r[15:0]}
        })
    );

    // store data trimmed to the access width.
    key_mux #(
        .NR_KEY(`ST_NR_KEY),
        .key_t (rv_isa_pkg::funct3_t),
        .data_t(rv_isa_pkg::word_t)
    ) store_mux (
        .out        (mem_2_w),
        .key        (funct3),
        .default_out(rv_isa_pkg::word_t'(0)),
        .lut        ({
            rv_isa_pkg::F3_B, {{(`XLEN-8){1'b0}}, src2[7:0]},
            rv_isa_pkg::F3_H, {{(`XLEN-16){1'b0}}, src2[15:0]},
            rv_isa_pkg::F3_W, src2
        })
    );

    assign mem_2_addr = alu_result;
    assign mem_2_mask = mem_mask;
    assign mem_2_r_en = mem_r_en;
    assign mem_2_w_en = mem_w_en;

endmodule

// File: hw/mem_decode.sv
`include "lsu_cfg.svh"

module mem_decode (
    input  rv_isa_pkg::opcode_t opcode,
    input  rv_isa_pkg::funct3_t funct3,
    input  rv_isa_pkg::word_t   rs1_val,
    input  rv_isa_pkg::word_t   imm,
    output rv_isa_pkg::word_t   addr,
    output mem_pkg::mask_t      mem_mask,
    output logic                mem_r_en,
    output logic                mem_w_en,
    output logic                misaligned
);

    mem_pkg::offset_t offset;
    logic             is_load;
    logic             is_store;
    logic             aligned;
    logic             known_width;

    assign addr   = rs1_val + imm;
    assign offset = addr[$bits(mem_pkg::offset_t)-1:0];

    key_mux #(
        .NR_KEY(`MASK_NR_KEY),
        .key_t (rv_isa_pkg::funct3_t),
        .data_t(mem_pkg::mask_t)
    ) mask_mux (
        .out        (mem_mask),
        .key        (funct3),
        .default_out(mem_pkg::mask_t'(0)),
        .lut        ({
            rv_isa_pkg::F3_B,  mem_pkg::MASK_B,
            rv_isa_pkg::F3_H,  mem_pkg::MASK_H,
            rv_isa_pkg::F3_W,  mem_pkg::MASK_W,
            rv_isa_pkg::F3_BU, mem_pkg::MASK_B,
            rv_isa_pkg::F3_HU, mem_pkg::MASK_H
        })
    );

    // natural alignment by access width.
    always_comb begin
        case (funct3)
            rv_isa_pkg::F3_H, rv_isa_pkg::F3_HU: aligned = ~offset[0];
            rv_isa_pkg::F3_W:                    aligned = (offset == '0);
            default:                             aligned = 1'b1;
        endcase
    end

    assign is_load     = (opcode == rv_isa_pkg::OP_LOAD);
    assign is_store    = (opcode == rv_isa_pkg::OP_STORE);
    assign known_width = |mem_mask;

    // misaligned accesses never reach memory.
    assign mem_r_en   = is_load & aligned & known_width;
    assign mem_w_en   = is_store & aligned & known_width;
    assign misaligned = (is_load | is_store) & ~aligned;

endmodule

// File: hw/key_mux.sv
module key_mux #(
    parameter int  NR_KEY = 2,
    parameter type key_t  = logic,
    parameter type data_t = logic
) (
    output data_t out,
    input  key_t  key,
    input  data_t default_out,
    input  logic  [NR_KEY-1:0][$bits(key_t)+$bits(data_t)-1:0] lut
);

    localparam int KEY_W  = $bits(key_t);
    localparam int DATA_W = $bits(data_t);

    // each entry holds the key above its data.
    always_comb begin
        out = default_out;
        for (int i = 0; i < NR_KEY; i++) begin
            if (lut[i][KEY_W+DATA_W-1 -: KEY_W] == key) begin
                out = data_t'(lut[i][DATA_W-1:0]);
            end
        end
    end

endmodule

// File: hw/mem_pkg.sv
`include "lsu_cfg.svh"

package mem_pkg;

    // one bit per byte lane, right-justified.
    typedef logic [`XLEN/8-1:0] mask_t;

    // byte position inside a word.
    typedef logic [$clog2(`XLEN/8)-1:0] offset_t;

    // word position inside the data memory.
    typedef logic [`MEM_AW-1:0] index_t;

    localparam mask_t MASK_B = 4'b0001;
    localparam mask_t MASK_H = 4'b0011;
    localparam mask_t MASK_W = 4'b1111;

endpackage

// File: hw/rv_isa_pkg.sv
`include "lsu_cfg.svh"

package rv_isa_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] opcode_t;

    // major opcodes handled by the memory stage.
    localparam opcode_t OP_LOAD  = 7'b0000011;
    localparam opcode_t OP_STORE = 7'b0100011;

    // access width codes.
    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

endpackage

// File: hw/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data word width.
`define XLEN 32

// word index width, 256 words.
`define MEM_AW 8

// entries in each keyed lookup.
`define LD_NR_KEY 5
`define ST_NR_KEY 3
`define MASK_NR_KEY 5

`endif
